//--- list.f
common/pqm_pkg.sv
common/link_if.sv
common/qtab_if.sv
queue/link_ram.sv
queue/queue_table.sv
verilog/prior_sched.sv
verilog/pqm_ctrl.sv
verilog/pqm_top.sv
tests/pqm_tb_sva.sv
tests/pqm_tb.sv

//--- tests/pqm_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pqm_tb;

    localparam int NP          = pqm_pkg::NUM_PORTS;
    localparam int PW          = pqm_pkg::PRIOR_W;
    localparam int MQ_DEPTH    = 512;
    localparam int RAND_FRAMES = 40;
    // eleven directed frames come before the random ones
    localparam int TOTAL_FRAMES = 11 + RAND_FRAMES;
    // at most four cells per frame
    localparam int CYCLE_LIMIT  = 40 * 4 * TOTAL_FRAMES + 200;

    logic                i_clk = 1'b0;
    logic                i_rst;
    logic                i_vld;
    pqm_pkg::port_t      i_da;
    pqm_pkg::prior_t     i_prior;
    logic                i_addr_in_vld;
    pqm_pkg::cell_addr_t i_addr_in;
    logic                i_frame_last;
    logic                o_addr_in_rdy;
    logic                i_out_vld;
    pqm_pkg::port_t      i_out_port;
    logic                i_addr_out_rdy;
    logic                o_addr_out_vld;
    pqm_pkg::cell_addr_t o_addr_out;
    logic                o_frame_last;
    logic                o_addr_rls_vld;
    pqm_pkg::cell_addr_t o_addr_rls;
    logic [NP-1:0]       o_out_pending;
    logic [NP*PW-1:0]    o_out_prior;

    integer              seed = 32'hf150e34f;
    int                  cycle_cnt = 0;
    logic                stall_en = 1'b0;
    logic                prev_out_vld = 1'b0;
    logic                prev_rdy = 1'b1;

    // circular model queue per queue id
    pqm_pkg::cell_addr_t mq_addr   [pqm_pkg::NUM_QUEUES][MQ_DEPTH];
    bit                  mq_last   [pqm_pkg::NUM_QUEUES][MQ_DEPTH];
    int                  mq_head   [pqm_pkg::NUM_QUEUES];
    int                  mq_tail   [pqm_pkg::NUM_QUEUES];
    int                  mq_frames [pqm_pkg::NUM_QUEUES];
    pqm_pkg::cell_addr_t free_q [$];
    pqm_pkg::cell_addr_t exp_out [$];
    bit                  exp_last [$];
    pqm_pkg::cell_addr_t exp_rls [$];

    pqm_top u_pqm_top (.*);

    always #5 i_clk = ~i_clk;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    function automatic bit port_busy(input int port);
        for (int k = 0; k < pqm_pkg::NUM_PRIOR; k++) begin
            if (mq_frames[port * pqm_pkg::NUM_PRIOR + k] > 0) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // lowest priority number holding a complete frame
    function automatic pqm_pkg::prior_t model_pick(input int port);
        for (int k = 0; k < pqm_pkg::NUM_PRIOR; k++) begin
            if (mq_frames[port * pqm_pkg::NUM_PRIOR + k] > 0) begin
                return pqm_pkg::prior_t'(k);
            end
        end
        return '0;
    endfunction

    function automatic void model_status(output logic [NP-1:0] pend,
                                         output logic [NP*PW-1:0] prio);
        for (int p = 0; p < NP; p++) begin
            pend[p]         = port_busy(p);
            prio[p*PW +: PW] = model_pick(p);
        end
    endfunction

    // moves the head frame of the picked queue into the expected stream
    function automatic void expect_frame(input pqm_pkg::port_t port);
        int qi;
        bit last;
        qi   = port * pqm_pkg::NUM_PRIOR + model_pick(port);
        last = 1'b0;
        while (!last) begin
            last = mq_last[qi][mq_head[qi] % MQ_DEPTH];
            exp_out.push_back(mq_addr[qi][mq_head[qi] % MQ_DEPTH]);
            exp_last.push_back(last);
            mq_head[qi]++;
        end
        mq_frames[qi]--;
    endfunction

    function automatic bit model_drained();
        for (int q = 0; q < pqm_pkg::NUM_QUEUES; q++) begin
            if (mq_head[q] != mq_tail[q]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic pqm_pkg::cell_addr_t take_free();
        int idx;
        pqm_pkg::cell_addr_t a;
        idx = $unsigned($random(seed)) % free_q.size();
        a   = free_q[idx];
        free_q.delete(idx);
        return a;
    endfunction

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_addr(input string what, input pqm_pkg::cell_addr_t got,
                              input pqm_pkg::cell_addr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s is %0d, expected %0d",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_prior(input int port, input pqm_pkg::prior_t got,
                               input pqm_pkg::prior_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: priority of port %0d is %0d, expected %0d",
                                    $time, port, got, exp));
        end
    endtask

    task automatic check_pending(input logic [NP-1:0] got, input logic [NP-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: pending is %h, expected %h",
                                    $time, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s is %b, expected %b",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_status();
        logic [NP-1:0]    pend;
        logic [NP*PW-1:0] prio;
        model_status(pend, prio);
        check_pending(o_out_pending, pend);
        for (int p = 0; p < NP; p++) begin
            check_prior(p, o_out_prior[p*PW +: PW], prio[p*PW +: PW]);
        end
    endtask

    // output stream against the model at the falling edge
    always @(negedge i_clk) begin
        if (!i_rst) begin
            check_flag("o_addr_rls_vld", o_addr_rls_vld, prev_out_vld);
            if (o_addr_rls_vld && exp_rls.size() == 0) begin
                stop_on_error("address released with no cell output before it");
            end else if (o_addr_rls_vld) begin
                check_addr("o_addr_rls", o_addr_rls, exp_rls[0]);
                free_q.push_back(exp_rls.pop_front());
            end
            if (o_addr_out_vld && !prev_rdy) begin
                stop_on_error("cell issued while out-ready was low");
            end
            if (o_addr_out_vld && exp_out.size() == 0) begin
                stop_on_error("output cell while no frame was expected");
            end else if (o_addr_out_vld) begin
                check_addr("o_addr_out", o_addr_out, exp_out[0]);
                check_flag("o_frame_last", o_frame_last, exp_last[0]);
                exp_rls.push_back(exp_out.pop_front());
                void'(exp_last.pop_front());
            end else begin
                check_flag("o_frame_last", o_frame_last, 1'b0);
            end
            prev_out_vld = o_addr_out_vld;
            prev_rdy     = i_addr_out_rdy;
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            stop_on_error($sformatf("timeout: run did not finish in %0d cycles",
                                    CYCLE_LIMIT));
        end
    end

    // sink stalls
    always @(posedge i_clk) begin
        if (stall_en) begin
            i_addr_out_rdy <= ($unsigned($random(seed)) % 3) != 0;
        end else begin
            i_addr_out_rdy <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic enqueue(input pqm_pkg::port_t port, input pqm_pkg::prior_t prio,
                           input int len);
        int qi;
        pqm_pkg::cell_addr_t cells [$];
        qi = port * pqm_pkg::NUM_PRIOR + prio;
        @(posedge i_clk);
        i_vld   <= 1'b1;
        i_da    <= port;
        i_prior <= prio;
        @(posedge i_clk);
        i_vld   <= 1'b0;
        // no cell is taken in the cycle after the strobe
        @(negedge i_clk);
        check_flag("o_addr_in_rdy", o_addr_in_rdy, 1'b0);
        for (int k = 0; k < len; k++) begin
            cells.push_back(take_free());
        end
        for (int k = 0; k < len; k++) begin
            @(posedge i_clk);
            i_addr_in_vld <= 1'b1;
            i_addr_in     <= cells[k];
            i_frame_last  <= (k == len - 1);
            @(negedge i_clk);
            if (!o_addr_in_rdy) begin
                stop_on_error("input not ready while a frame was being sent");
            end
            mq_addr[qi][mq_tail[qi] % MQ_DEPTH] = cells[k];
            mq_last[qi][mq_tail[qi] % MQ_DEPTH] = (k == len - 1);
            mq_tail[qi]++;
        end
        @(posedge i_clk);
        i_addr_in_vld <= 1'b0;
        i_frame_last  <= 1'b0;
        mq_frames[qi]++;
        @(negedge i_clk);
        check_status();
    endtask

    task automatic dequeue(input pqm_pkg::port_t port);
        expect_frame(port);
        @(posedge i_clk);
        i_out_vld  <= 1'b1;
        i_out_port <= port;
        @(posedge i_clk);
        i_out_vld  <= 1'b0;
        // enqueue is held off for the whole dequeue
        do begin
            @(negedge i_clk);
            check_flag("o_addr_in_rdy", o_addr_in_rdy, 1'b0);
        end while (!(o_addr_out_vld && o_frame_last));
        @(negedge i_clk);
        check_flag("o_addr_in_rdy", o_addr_in_rdy, 1'b1);
        check_status();
    endtask

    initial begin
        int s;
        pqm_pkg::port_t p;
        i_rst          = 1'b1;
        i_vld          = 1'b0;
        i_da           = '0;
        i_prior        = '0;
        i_addr_in_vld  = 1'b0;
        i_addr_in      = '0;
        i_frame_last   = 1'b0;
        i_out_vld      = 1'b0;
        i_out_port     = '0;
        i_addr_out_rdy = 1'b1;
        for (int a = 0; a < pqm_pkg::LINK_DEPTH; a++) begin
            free_q.push_back(a);
        end

        // idle state under reset
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        check_flag("o_addr_in_rdy", o_addr_in_rdy, 1'b0);
        check_flag("o_addr_out_vld", o_addr_out_vld, 1'b0);
        check_flag("o_frame_last", o_frame_last, 1'b0);
        check_flag("o_addr_rls_vld", o_addr_rls_vld, 1'b0);
        check_status();
        @(posedge i_clk);
        i_rst <= 1'b0;

        // request on an empty port must do nothing
        @(posedge i_clk);
        i_out_vld  <= 1'b1;
        i_out_port <= 4'd9;
        @(posedge i_clk);
        i_out_vld  <= 1'b0;
        repeat (6) @(negedge i_clk);
        check_status();

        // single frame
        enqueue(4'd3, 3'd2, 4);
        dequeue(4'd3);

        // strict priority and FIFO order within a level
        enqueue(4'd5, 3'd3, 2);
        enqueue(4'd5, 3'd1, 1);
        enqueue(4'd5, 3'd6, 3);
        enqueue(4'd5, 3'd1, 2);
        enqueue(4'd5, 3'd0, 1);
        enqueue(4'd5, 3'd3, 1);
        while (port_busy(5)) begin
            dequeue(4'd5);
        end

        // sink stalls
        stall_en = 1'b1;
        enqueue(4'd2, 3'd4, 4);
        enqueue(4'd2, 3'd4, 3);
        enqueue(4'd2, 3'd7, 2);
        enqueue(4'd11, 3'd0, 4);
        while (port_busy(2)) begin
            dequeue(4'd2);
        end
        dequeue(4'd11);

        // random traffic until drained
        s = RAND_FRAMES;
        while (s > 0 || !model_drained()) begin
            if (s > 0 && (model_drained() || $random(seed) % 2 == 0)) begin
                enqueue($unsigned($random(seed)) % NP,
                        $unsigned($random(seed)) % pqm_pkg::NUM_PRIOR,
                        1 + $unsigned($random(seed)) % 4);
                s--;
            end else begin
                p = $unsigned($random(seed)) % NP;
                while (!port_busy(p)) begin
                    p = p + 1'b1;
                end
                dequeue(p);
            end
        end

        repeat (4) @(negedge i_clk);
        if (exp_out.size() != 0 || exp_rls.size() != 0 || !model_drained()
            || free_q.size() != pqm_pkg::LINK_DEPTH) begin
            stop_on_error("run ended with cells not output or not released");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/pqm_tb_sva.sv
`timescale 1ns/100ps
`default_nettype none

module pqm_tb_sva (
    input wire                      i_clk,
    input wire                      i_rst,
    input wire                      i_addr_out_rdy,
    input wire                      o_addr_out_vld,
    input wire pqm_pkg::cell_addr_t o_addr_out,
    input wire                      o_frame_last,
    input wire                      o_addr_rls_vld,
    input wire pqm_pkg::cell_addr_t o_addr_rls
);

    // release one cycle after each output, same address
    a_rls_follows_out: assert property (@(posedge i_clk) disable iff (i_rst)
        o_addr_out_vld |=> o_addr_rls_vld && o_addr_rls == $past(o_addr_out))
        else $error("release missing or wrong after an output cell");

    a_rls_has_out: assert property (@(posedge i_clk) disable iff (i_rst)
        o_addr_rls_vld |-> $past(o_addr_out_vld))
        else $error("release without an output cell before it");

    // a cell is only issued while the sink was ready
    a_no_issue_stalled: assert property (@(posedge i_clk) disable iff (i_rst)
        o_addr_out_vld |-> $past(i_addr_out_rdy))
        else $error("output cell issued while out-ready was low");

    a_last_with_vld: assert property (@(posedge i_clk) disable iff (i_rst)
        o_frame_last |-> o_addr_out_vld)
        else $error("frame last flag without an output cell");

endmodule

bind pqm_top pqm_tb_sva u_pqm_tb_sva (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_addr_out_rdy (i_addr_out_rdy),
    .o_addr_out_vld (o_addr_out_vld),
    .o_addr_out     (o_addr_out),
    .o_frame_last   (o_frame_last),
    .o_addr_rls_vld (o_addr_rls_vld),
    .o_addr_rls     (o_addr_rls)
);

`default_nettype wire

//--- verilog/pqm_top.sv
`timescale 1ns/100ps
`default_nettype none

module pqm_top (
    input  wire                                         i_clk,
    input  wire                                         i_rst,

    // enqueue
    input  wire                                         i_vld,
    input  wire  pqm_pkg::port_t                        i_da,
    input  wire  pqm_pkg::prior_t                       i_prior,
    input  wire                                         i_addr_in_vld,
    input  wire  pqm_pkg::cell_addr_t                   i_addr_in,
    input  wire                                         i_frame_last,
    output logic                                        o_addr_in_rdy,

    // dequeue
    input  wire                                         i_out_vld,
    input  wire  pqm_pkg::port_t                        i_out_port,
    input  wire                                         i_addr_out_rdy,
    output logic                                        o_addr_out_vld,
    output pqm_pkg::cell_addr_t                         o_addr_out,
    output logic                                        o_frame_last,
    output logic                                        o_addr_rls_vld,
    output pqm_pkg::cell_addr_t                         o_addr_rls,

    // status
    output logic [pqm_pkg::NUM_PORTS-1:0]               o_out_pending,
    output logic [pqm_pkg::NUM_PORTS*pqm_pkg::PRIOR_W-1:0] o_out_prior
);

    logic [pqm_pkg::NUM_QUEUES-1:0] frame_nonzero;

    link_if u_link_if ();
    qtab_if u_qtab_if ();

    pqm_ctrl u_pqm_ctrl (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_vld          (i_vld),
        .i_da           (i_da),
        .i_prior        (i_prior),
        .i_addr_in_vld  (i_addr_in_vld),
        .i_addr_in      (i_addr_in),
        .i_frame_last   (i_frame_last),
        .o_addr_in_rdy  (o_addr_in_rdy),
        .i_out_vld      (i_out_vld),
        .i_out_port     (i_out_port),
        .i_addr_out_rdy (i_addr_out_rdy),
        .o_addr_out_vld (o_addr_out_vld),
        .o_addr_out     (o_addr_out),
        .o_frame_last   (o_frame_last),
        .o_addr_rls_vld (o_addr_rls_vld),
        .o_addr_rls     (o_addr_rls),
        .qt             (u_qtab_if.ctrl),
        .lk             (u_link_if.reader),
        .i_pending      (o_out_pending),
        .i_prior_sel    (o_out_prior)
    );

    queue_table u_queue_table (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .qt              (u_qtab_if.tbl),
        .lk              (u_link_if.writer),
        .o_frame_nonzero (frame_nonzero)
    );

    link_ram u_link_ram (
        .i_clk (i_clk),
        .lk    (u_link_if.ram)
    );

    prior_sched u_prior_sched (
        .i_frame_nonzero (frame_nonzero),
        .o_out_pending   (o_out_pending),
        .o_out_prior     (o_out_prior)
    );

endmodule

`default_nettype wire

//--- verilog/pqm_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module pqm_ctrl (
    input  wire                                         i_clk,
    input  wire                                         i_rst,

    // enqueue
    input  wire                                         i_vld,
    input  wire  pqm_pkg::port_t                        i_da,
    input  wire  pqm_pkg::prior_t                       i_prior,
    input  wire                                         i_addr_in_vld,
    input  wire  pqm_pkg::cell_addr_t                   i_addr_in,
    input  wire                                         i_frame_last,
    output logic                                        o_addr_in_rdy,

    // dequeue
    input  wire                                         i_out_vld,
    input  wire  pqm_pkg::port_t                        i_out_port,
    input  wire                                         i_addr_out_rdy,
    output logic                                        o_addr_out_vld,
    output pqm_pkg::cell_addr_t                         o_addr_out,
    output logic                                        o_frame_last,
    output logic                                        o_addr_rls_vld,
    output pqm_pkg::cell_addr_t                         o_addr_rls,

    qtab_if.ctrl                                        qt,
    link_if.reader                                      lk,

    // scheduler status
    input  wire  [pqm_pkg::NUM_PORTS-1:0]               i_pending,
    input  wire  [pqm_pkg::NUM_PORTS*pqm_pkg::PRIOR_W-1:0] i_prior_sel
);

    logic [pqm_pkg::ST_W-1:0]   state_q;
    logic [pqm_pkg::ST_W-1:0]   state_d;
    pqm_pkg::queue_id_u         qid_q;
    pqm_pkg::queue_id_u         qid_d;
    logic                       in_rdy_q;
    logic                       out_vld_q;
    logic                       out_last_q;
    logic                       rls_vld_q;
    pqm_pkg::cell_addr_t        out_addr_q;
    pqm_pkg::cell_addr_t        rls_addr_q;

    logic                       vld_acc;
    logic                       push_ok;
    logic                       deq_start;
    logic                       issue;

    ////////////////////////////////////////
    // request decode
    ////////////////////////////////////////
    assign vld_acc   = i_vld && (state_q == pqm_pkg::ST_IDLE || state_q == pqm_pkg::ST_ENQ);
    assign push_ok   = state_q == pqm_pkg::ST_ENQ && i_addr_in_vld && in_rdy_q;
    // enqueue strobe wins over a dequeue request
    assign deq_start = state_q == pqm_pkg::ST_IDLE && !i_vld && i_out_vld
                       && i_pending[i_out_port];
    assign issue     = state_q == pqm_pkg::ST_ISSUE && i_addr_out_rdy && qt.nonempty;

    always_comb begin
        state_d = state_q;
        case (state_q)
            pqm_pkg::ST_IDLE: begin
                if (vld_acc) begin
                    state_d = pqm_pkg::ST_ENQ;
                end else if (deq_start) begin
                    state_d = pqm_pkg::ST_ISSUE;
                end
            end
            pqm_pkg::ST_ENQ: begin
                if (!vld_acc && push_ok && i_frame_last) begin
                    state_d = pqm_pkg::ST_IDLE;
                end
            end
            pqm_pkg::ST_ISSUE: begin
                if (issue) begin
                    state_d = pqm_pkg::ST_WAIT;
                end
            end
            default: begin
                // link word arrives here, frame ends on the head flag
                state_d = qt.head_last ? pqm_pkg::ST_IDLE : pqm_pkg::ST_ISSUE;
            end
        endcase
    end

    // latched queue, from the enqueue strobe or the scheduler pick
    always_comb begin
        qid_d = qid_q;
        if (vld_acc) begin
            qid_d.f.port  = i_da;
            qid_d.f.prior = i_prior;
        end else if (deq_start) begin
            qid_d.f.port  = i_out_port;
            qid_d.f.prior = i_prior_sel[i_out_port*pqm_pkg::PRIOR_W +: pqm_pkg::PRIOR_W];
        end
    end

    ////////////////////////////////////////
    // state and strobes
    ////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q    <= pqm_pkg::ST_IDLE;
            qid_q      <= '0;
            in_rdy_q   <= 1'b0;
            out_vld_q  <= 1'b0;
            out_last_q <= 1'b0;
            rls_vld_q  <= 1'b0;
        end else begin
            state_q    <= state_d;
            qid_q      <= qid_d;
            // low right after a strobe and for the whole dequeue
            in_rdy_q   <= !vld_acc && (state_d == pqm_pkg::ST_IDLE
                                       || state_d == pqm_pkg::ST_ENQ);
            out_vld_q  <= issue;
            out_last_q <= issue && qt.head_last;
            rls_vld_q  <= out_vld_q;
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue) begin
            out_addr_q <= qt.head;
        end
        if (out_vld_q) begin
            rls_addr_q <= out_addr_q;
        end
    end

    ////////////////////////////////////////
    // table and link memory
    ////////////////////////////////////////
    assign qt.qid       = qid_q;
    assign qt.push      = push_ok;
    assign qt.push_addr = i_addr_in;
    assign qt.push_last = i_frame_last;
    // pop once the head's link word is back
    assign qt.pop       = state_q == pqm_pkg::ST_WAIT;
    assign qt.pop_word  = lk.rd_data;
    assign qt.pop_end   = qt.head_last;

    assign lk.rd_en   = issue;
    assign lk.rd_addr = qt.head;

    assign o_addr_in_rdy  = in_rdy_q;
    assign o_addr_out_vld = out_vld_q;
    assign o_addr_out     = out_addr_q;
    assign o_frame_last   = out_last_q;
    assign o_addr_rls_vld = rls_vld_q;
    assign o_addr_rls     = rls_addr_q;

endmodule

`default_nettype wire

//--- verilog/prior_sched.sv
`timescale 1ns/100ps
`default_nettype none

module prior_sched (
    input  wire  [pqm_pkg::NUM_QUEUES-1:0]              i_frame_nonzero,
    output logic [pqm_pkg::NUM_PORTS-1:0]               o_out_pending,
    output logic [pqm_pkg::NUM_PORTS*pqm_pkg::PRIOR_W-1:0] o_out_prior
);

    // queue index is port * NUM_PRIOR + priority
    for (genvar p = 0; p < pqm_pkg::NUM_PORTS; p++) begin : g_port
        logic [pqm_pkg::NUM_PRIOR-1:0] busy;
        pqm_pkg::prior_t               pick;

        assign busy = i_frame_nonzero[p*pqm_pkg::NUM_PRIOR +: pqm_pkg::NUM_PRIOR];

        assign o_out_pending[p] = |busy;

        // strict priority, 0 wins
        always_comb begin
            pick = '0;
            for (int k = pqm_pkg::NUM_PRIOR - 1; k >= 0; k--) begin
                if (busy[k]) begin
                    pick = pqm_pkg::prior_t'(k);
                end
            end
        end

        assign o_out_prior[p*pqm_pkg::PRIOR_W +: pqm_pkg::PRIOR_W] = pick;
    end

endmodule

`default_nettype wire

//--- queue/queue_table.sv
`timescale 1ns/100ps
`default_nettype none

module queue_table (
    input  wire                                 i_clk,
    input  wire                                 i_rst,
    qtab_if.tbl                                 qt,
    link_if.writer                              lk,
    output logic [pqm_pkg::NUM_QUEUES-1:0]      o_frame_nonzero
);

    pqm_pkg::cell_addr_t            head_q      [pqm_pkg::NUM_QUEUES];
    pqm_pkg::cell_addr_t            tail_q      [pqm_pkg::NUM_QUEUES];
    logic                           head_last_q [pqm_pkg::NUM_QUEUES];
    logic [pqm_pkg::CNT_W-1:0]      frame_cnt_q [pqm_pkg::NUM_QUEUES];
    logic [pqm_pkg::NUM_QUEUES-1:0] nonempty_q;
    logic [pqm_pkg::QID_W-1:0]      qi;
    logic                           pop_drains;

    assign qi         = qt.qid.idx;
    assign pop_drains = head_q[qi] == tail_q[qi];

    ////////////////////////////////////////
    // occupancy and frame counts
    ////////////////////////////////////////
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            nonempty_q <= '0;
            for (int i = 0; i < pqm_pkg::NUM_QUEUES; i++) begin
                frame_cnt_q[i] <= '0;
            end
        end else if (qt.push) begin
            nonempty_q[qi] <= 1'b1;
            // only complete frames count
            if (qt.push_last) begin
                frame_cnt_q[qi] <= frame_cnt_q[qi] + 1'b1;
            end
        end else if (qt.pop) begin
            if (pop_drains) begin
                nonempty_q[qi] <= 1'b0;
            end
            if (qt.pop_end) begin
                frame_cnt_q[qi] <= frame_cnt_q[qi] - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // head and tail pointers
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (qt.push) begin
            tail_q[qi] <= qt.push_addr;
            // first cell of an empty queue becomes head
            if (!nonempty_q[qi]) begin
                head_q[qi]      <= qt.push_addr;
                head_last_q[qi] <= qt.push_last;
            end
        end else if (qt.pop && !pop_drains) begin
            head_q[qi]      <= qt.pop_word.next;
            head_last_q[qi] <= qt.pop_word.next_last;
        end
    end

    // chain the new cell behind the old tail
    assign lk.wr_en   = qt.push && nonempty_q[qi];
    assign lk.wr_addr = tail_q[qi];
    assign lk.wr_data = {qt.push_addr, qt.push_last};

    // head view of the selected queue
    assign qt.head      = head_q[qi];
    assign qt.head_last = head_last_q[qi];
    assign qt.nonempty  = nonempty_q[qi];

    always_comb begin
        for (int q = 0; q < pqm_pkg::NUM_QUEUES; q++) begin
            o_frame_nonzero[q] = |frame_cnt_q[q];
        end
    end

endmodule

`default_nettype wire

//--- queue/link_ram.sv
`timescale 1ns/100ps
`default_nettype none

module link_ram (
    input  wire     i_clk,
    link_if.ram     lk
);

    // one link word per buffer cell
    pqm_pkg::link_word_t mem [pqm_pkg::LINK_DEPTH];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (lk.wr_en) begin
            mem[lk.wr_addr] <= lk.wr_data;
        end
    end

    ////////////////////////////////////////
    // read port
    ////////////////////////////////////////
    // registered, holds until the next read
    always_ff @(posedge i_clk) begin
        if (lk.rd_en) begin
            lk.rd_data <= mem[lk.rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- common/qtab_if.sv
`timescale 1ns/100ps
`default_nettype none

interface qtab_if;

    // queue under work
    pqm_pkg::queue_id_u     qid;

    // append one cell
    logic                   push;
    pqm_pkg::cell_addr_t    push_addr;
    logic                   push_last;

    // drop the head cell
    logic                   pop;
    pqm_pkg::link_word_t    pop_word;
    logic                   pop_end;

    // head state of qid
    pqm_pkg::cell_addr_t    head;
    logic                   head_last;
    logic                   nonempty;

    modport ctrl (
        output qid,
        output push, push_addr, push_last,
        output pop, pop_word, pop_end,
        input  head, head_last, nonempty
    );

    modport tbl (
        input  qid,
        input  push, push_addr, push_last,
        input  pop, pop_word, pop_end,
        output head, head_last, nonempty
    );

endinterface

`default_nettype wire

//--- common/link_if.sv
`timescale 1ns/100ps
`default_nettype none

interface link_if;

    // write port, driven by the queue table on push
    logic                   wr_en;
    pqm_pkg::cell_addr_t    wr_addr;
    pqm_pkg::link_word_t    wr_data;

    // read port, data one cycle after rd_en
    logic                   rd_en;
    pqm_pkg::cell_addr_t    rd_addr;
    pqm_pkg::link_word_t    rd_data;

    modport writer (
        output wr_en, wr_addr, wr_data
    );

    modport reader (
        output rd_en, rd_addr,
        input  rd_data
    );

    modport ram (
        input  wr_en, wr_addr, wr_data,
        input  rd_en, rd_addr,
        output rd_data
    );

endinterface

`default_nettype wire

//--- common/pqm_pkg.sv
`default_nettype none

package pqm_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    localparam int NUM_PORTS  = 16;
    localparam int NUM_PRIOR  = 8;
    localparam int NUM_QUEUES = NUM_PORTS * NUM_PRIOR;
    localparam int PORT_W     = 4;
    localparam int PRIOR_W    = 3;
    localparam int QID_W      = PORT_W + PRIOR_W;
    localparam int ADDR_W     = 10;
    localparam int CNT_W      = 10;
    localparam int LINK_DEPTH = 1 << ADDR_W;

    // controller states
    localparam int         ST_W     = 2;
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ENQ   = 2'd1;
    localparam logic [1:0] ST_ISSUE = 2'd2;
    localparam logic [1:0] ST_WAIT  = 2'd3;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////
    typedef logic [ADDR_W-1:0]  cell_addr_t;
    typedef logic [PRIOR_W-1:0] prior_t;
    typedef logic [PORT_W-1:0]  port_t;

    // queue id, flat table index or port/priority pair
    typedef union packed {
        logic [QID_W-1:0] idx;
        struct packed {
            port_t  port;
            prior_t prior;
        } f;
    } queue_id_u;

    // successor of a cell in its queue
    typedef struct packed {
        cell_addr_t next;
        logic       next_last;
    } link_word_t;

endpackage

`default_nettype wire
